/* dep_check.f */
+incdir+.
dep_check_pkg.sv
dep_check_ifs.sv
uop_collector.sv
raw_dep_matrix.sv
dep_priority_enc.sv
out_credit_ctrl.sv
dep_check_top.sv
tb_dep_check.sv

/* dep_check_defines.svh */
`ifndef DEP_CHECK_DEFINES_SVH
`define DEP_CHECK_DEFINES_SVH

//////////////////////////////
// window geometry
`define DC_LANES        4       // uops per beat.
`define DC_SLOTS        8       // two beats per window.

//////////////////////////////
// field widths
`define DC_REG_W        5
`define DC_UOP_W        32

//////////////////////////////
// flow control
`define DC_IN_CREDITS   2       // beats upstream may send after reset.
`define DC_OUT_CREDITS  2       // windows downstream can take after reset.

`define DC_NO_DEP       4'hF    // no older producer.

`endif

/* dep_check_ifs.sv */
`include "dep_check_defines.svh"

//////////////////////////////
// matrix -> encoder
interface match_if;
    logic                                        valid;
    logic                                        ready;
    dep_check_pkg::uop_t       [`DC_SLOTS-1:0]   uops;
    dep_check_pkg::slot_mask_t [`DC_SLOTS-1:0]   match_l;   // per slot, older producers.
    dep_check_pkg::slot_mask_t [`DC_SLOTS-1:0]   match_r;

    modport src (output valid, output uops, output match_l, output match_r, input ready);
    modport dst (input valid, input uops, input match_l, input match_r, output ready);
endinterface

//////////////////////////////
// encoder -> output stage
interface dep_win_if;
    logic                                        valid;
    logic                                        ready;
    dep_check_pkg::uop_t       [`DC_SLOTS-1:0]   uops;
    dep_check_pkg::slot_idx_t  [`DC_SLOTS-1:0]   dep_l;
    dep_check_pkg::slot_idx_t  [`DC_SLOTS-1:0]   dep_r;

    modport src (output valid, output uops, output dep_l, output dep_r, input ready);
    modport dst (input valid, input uops, input dep_l, input dep_r, output ready);
endinterface

/* dep_check_pkg.sv */
`include "dep_check_defines.svh"

package dep_check_pkg;

    typedef logic [`DC_REG_W-1:0] reg_idx_t;    // architectural register.
    typedef logic [`DC_UOP_W-1:0] uop_t;

    // producer slot, DC_NO_DEP when none.
    typedef logic [3:0] slot_idx_t;

    typedef logic [`DC_SLOTS-1:0] slot_mask_t;  // bit k is slot k.
    typedef logic [1:0] credit_cnt_t;

    typedef enum logic [1:0] {
        COLL_EMPTY,
        COLL_HALF,     // first beat held in slots 0..3.
        COLL_FULL      // window waiting for the matrix.
    } coll_state_t;

endpackage

/* dep_check_top.sv */
`include "dep_check_defines.svh"

module dep_check_top (
    input  logic                                        w_fire01,
    input  logic                                        rstn,

    // upstream
    input  logic                                        i_in_valid,
    input  dep_check_pkg::uop_t      [`DC_LANES-1:0]    i_in_uops,
    output logic                                        o_in_credit,

    // downstream
    output logic                                        o_out_valid,
    output dep_check_pkg::uop_t      [`DC_SLOTS-1:0]    o_out_uops,
    output dep_check_pkg::slot_idx_t [`DC_SLOTS-1:0]    o_out_dep_l,
    output dep_check_pkg::slot_idx_t [`DC_SLOTS-1:0]    o_out_dep_r,
    input  logic                                        i_out_credit
);

    logic                                   w_win_valid;
    logic                                   w_win_ready;
    dep_check_pkg::uop_t [`DC_SLOTS-1:0]    w_win_uops;

    match_if    u_match ();
    dep_win_if  u_dep_win ();

    uop_collector u_collector (
        .w_fire01    (w_fire01),
        .rstn        (rstn),
        .i_in_valid  (i_in_valid),
        .i_in_uops   (i_in_uops),
        .o_in_credit (o_in_credit),
        .o_win_valid (w_win_valid),
        .o_win_uops  (w_win_uops),
        .i_win_ready (w_win_ready)
    );

    raw_dep_matrix u_matrix (
        .w_fire01    (w_fire01),
        .rstn        (rstn),
        .i_win_valid (w_win_valid),
        .i_win_uops  (w_win_uops),
        .o_win_ready (w_win_ready),
        .m           (u_match.src)
    );

    dep_priority_enc u_enc (
        .w_fire01 (w_fire01),
        .rstn     (rstn),
        .m        (u_match.dst),
        .d        (u_dep_win.src)
    );

    out_credit_ctrl u_out (
        .w_fire01     (w_fire01),
        .rstn         (rstn),
        .d            (u_dep_win.dst),
        .i_out_credit (i_out_credit),
        .o_out_valid  (o_out_valid),
        .o_out_uops   (o_out_uops),
        .o_out_dep_l  (o_out_dep_l),
        .o_out_dep_r  (o_out_dep_r)
    );

endmodule

/* dep_priority_enc.sv */
`include "dep_check_defines.svh"

module dep_priority_enc (
    input  logic        w_fire01,
    input  logic        rstn,
    match_if.dst        m,
    dep_win_if.src      d
);

    dep_check_pkg::slot_idx_t [`DC_SLOTS-1:0]   w_dep_l;
    dep_check_pkg::slot_idx_t [`DC_SLOTS-1:0]   w_dep_r;
    logic                                       r_valid;

    // highest set bit below slot, youngest older producer wins.
    function automatic dep_check_pkg::slot_idx_t nearest(
        input dep_check_pkg::slot_mask_t mask,
        input int                        slot
    );
        dep_check_pkg::slot_idx_t code;
        code = `DC_NO_DEP;
        for (int k = 0; k < `DC_SLOTS; k++) begin
            if (k < slot && mask[k]) begin
                code = dep_check_pkg::slot_idx_t'(k);
            end
        end
        return code;
    endfunction

    always_comb begin
        for (int j = 0; j < `DC_SLOTS; j++) begin
            w_dep_l[j] = nearest(m.match_l[j], j);
            w_dep_r[j] = nearest(m.match_r[j], j);
        end
    end

    assign m.ready = !r_valid || d.ready;
    assign d.valid = r_valid;

    always_ff @(posedge w_fire01 or negedge rstn) begin
        if (!rstn) begin
            r_valid <= 1'b0;
        end else if (m.ready) begin
            r_valid <= m.valid;
        end
    end

    always_ff @(posedge w_fire01) begin
        if (m.valid && m.ready) begin
            d.uops  <= m.uops;
            d.dep_l <= w_dep_l;
            d.dep_r <= w_dep_r;
        end
    end

endmodule

/* out_credit_ctrl.sv */
`include "dep_check_defines.svh"

module out_credit_ctrl (
    input  logic                                        w_fire01,
    input  logic                                        rstn,
    dep_win_if.dst                                      d,
    input  logic                                        i_out_credit,
    output logic                                        o_out_valid,
    output dep_check_pkg::uop_t      [`DC_SLOTS-1:0]    o_out_uops,
    output dep_check_pkg::slot_idx_t [`DC_SLOTS-1:0]    o_out_dep_l,
    output dep_check_pkg::slot_idx_t [`DC_SLOTS-1:0]    o_out_dep_r
);

    dep_check_pkg::credit_cnt_t r_credits;
    logic                       w_issue;

    assign d.ready = (r_credits != '0);
    assign w_issue = d.valid && d.ready;

    always_ff @(posedge w_fire01 or negedge rstn) begin
        if (!rstn) begin
            r_credits   <= dep_check_pkg::credit_cnt_t'(`DC_OUT_CREDITS);
            o_out_valid <= 1'b0;
        end else begin
            o_out_valid <= w_issue;         // one pulse per window.
            case ({w_issue, i_out_credit})
                2'b10:   r_credits <= r_credits - 2'd1;
                2'b01:   r_credits <= r_credits + 2'd1;
                default: r_credits <= r_credits;    // spend and return cancel.
            endcase
        end
    end

    always_ff @(posedge w_fire01) begin
        if (w_issue) begin
            o_out_uops  <= d.uops;
            o_out_dep_l <= d.dep_l;
            o_out_dep_r <= d.dep_r;
        end
    end

    //////////////////////////////
    // credit checks
    assert property (@(posedge w_fire01) disable iff (!rstn)
        r_credits <= `DC_OUT_CREDITS);

    // a window out leaves its credit with downstream.
    assert property (@(posedge w_fire01) disable iff (!rstn)
        o_out_valid |-> r_credits != `DC_OUT_CREDITS);

endmodule

/* raw_dep_matrix.sv */
`include "dep_check_defines.svh"

module raw_dep_matrix (
    input  logic                                    w_fire01,
    input  logic                                    rstn,
    input  logic                                    i_win_valid,
    input  dep_check_pkg::uop_t [`DC_SLOTS-1:0]     i_win_uops,
    output logic                                    o_win_ready,
    match_if.src                                    m
);

    dep_check_pkg::slot_mask_t [`DC_SLOTS-1:0]  w_match_l;
    dep_check_pkg::slot_mask_t [`DC_SLOTS-1:0]  w_match_r;
    logic                                       r_valid;

    // producer writes this source register.
    function automatic logic raw_hit(
        input dep_check_pkg::uop_t      prod,
        input logic                     src_vld,
        input dep_check_pkg::reg_idx_t  src
    );
        return prod[15] && src_vld && (prod[4:0] == src);
    endfunction

    // only older slots k < j can produce for slot j.
    always_comb begin
        w_match_l = '0;
        w_match_r = '0;
        for (int j = 1; j < `DC_SLOTS; j++) begin
            for (int k = 0; k < j; k++) begin
                w_match_l[j][k] = raw_hit(i_win_uops[k], i_win_uops[j][17],
                                          i_win_uops[j][14:10]);
                w_match_r[j][k] = raw_hit(i_win_uops[k], i_win_uops[j][16],
                                          i_win_uops[j][9:5]);
            end
        end
    end

    assign o_win_ready = !r_valid || m.ready;
    assign m.valid     = r_valid;

    always_ff @(posedge w_fire01 or negedge rstn) begin
        if (!rstn) begin
            r_valid <= 1'b0;
        end else if (o_win_ready) begin
            r_valid <= i_win_valid;
        end
    end

    always_ff @(posedge w_fire01) begin
        if (i_win_valid && o_win_ready) begin
            m.uops    <= i_win_uops;
            m.match_l <= w_match_l;
            m.match_r <= w_match_r;
        end
    end

endmodule

/* tb_dep_check.sv */
`include "dep_check_defines.svh"

module tb_dep_check;

    typedef dep_check_pkg::uop_t      [`DC_SLOTS-1:0] win_t;
    typedef dep_check_pkg::slot_idx_t [`DC_SLOTS-1:0] deps_t;

    localparam int PERIOD    = 4;
    localparam int N_WINDOWS = 29;                          // windows sent over all tests.
    localparam int WD_LIMIT  = (N_WINDOWS * 40 + 300) * PERIOD;

    logic                                   w_fire01;
    logic                                   rstn;
    logic                                   i_in_valid;
    dep_check_pkg::uop_t [`DC_LANES-1:0]    i_in_uops;
    logic                                   o_in_credit;
    logic                                   o_out_valid;
    win_t                                   o_out_uops;
    deps_t                                  o_out_dep_l;
    deps_t                                  o_out_dep_r;
    logic                                   i_out_credit;

    win_t           exp_uops_q[$];
    deps_t          exp_l_q[$];
    deps_t          exp_r_q[$];
    int             in_credits  = `DC_IN_CREDITS;
    int             out_credits = `DC_OUT_CREDITS;
    int             ret_pend    = 0;                        // downstream credits to hand back.
    int             in_pulses   = 0;
    int             rx_count    = 0;
    int             err_count   = 0;
    int             test_count  = 0;
    bit             auto_credit = 1'b1;
    logic [31:0]    lfsr_q      = 32'hd2a9_c969;

    dep_check_top i_dut (
        .w_fire01     (w_fire01),
        .rstn         (rstn),
        .i_in_valid   (i_in_valid),
        .i_in_uops    (i_in_uops),
        .o_in_credit  (o_in_credit),
        .o_out_valid  (o_out_valid),
        .o_out_uops   (o_out_uops),
        .o_out_dep_l  (o_out_dep_l),
        .o_out_dep_r  (o_out_dep_r),
        .i_out_credit (i_out_credit)
    );

    initial w_fire01 = 1'b0;
    always #(PERIOD / 2) w_fire01 = ~w_fire01;

    initial begin
        #(WD_LIMIT);
        $display("watchdog expired after %0d time units", WD_LIMIT);
        $display("Test failed");
        $finish;
    end

    //////////////////////////////
    // stimulus helpers
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic dep_check_pkg::uop_t mk_uop(
        input dep_check_pkg::reg_idx_t  dst,
        input logic                     dv,
        input dep_check_pkg::reg_idx_t  rs,
        input logic                     rv,
        input dep_check_pkg::reg_idx_t  ls,
        input logic                     lv
    );
        return {14'(rand_bits(14)), lv, rv, dv, ls, rs, dst};
    endfunction

    function automatic win_t rand_window();
        win_t w;
        for (int j = 0; j < `DC_SLOTS; j++) begin
            w[j] = mk_uop(5'(rand_bits(3)), 1'(rand_bits(1)), 5'(rand_bits(3)),
                          1'(rand_bits(1)), 5'(rand_bits(3)),
                          1'(rand_bits(1)));                // narrow regs give many hits.
        end
        return w;
    endfunction

    // youngest older slot whose valid destination equals the valid source.
    function automatic deps_t ref_deps(input win_t w, input bit left);
        deps_t                      d;
        logic                       sv;
        dep_check_pkg::reg_idx_t    sr;
        for (int j = 0; j < `DC_SLOTS; j++) begin
            sv   = left ? w[j][17] : w[j][16];
            sr   = left ? w[j][14:10] : w[j][9:5];
            d[j] = `DC_NO_DEP;
            for (int k = j - 1; k >= 0; k--) begin
                if (sv && w[k][15] && w[k][4:0] == sr && d[j] == `DC_NO_DEP) begin
                    d[j] = dep_check_pkg::slot_idx_t'(k);
                end
            end
        end
        return d;
    endfunction

    task automatic send_beat(input dep_check_pkg::uop_t [`DC_LANES-1:0] beat);
        while (in_credits == 0) begin
            i_in_valid <= 1'b0;
            @(posedge w_fire01);
        end
        i_in_valid <= 1'b1;
        i_in_uops  <= beat;
        in_credits--;
        @(posedge w_fire01);
    endtask

    task automatic send_window(input win_t w);
        exp_uops_q.push_back(w);
        exp_l_q.push_back(ref_deps(w, 1'b1));
        exp_r_q.push_back(ref_deps(w, 1'b0));
        send_beat(w[`DC_LANES-1:0]);
        send_beat(w[`DC_SLOTS-1:`DC_LANES]);
        i_in_valid <= 1'b0;
    endtask

    task automatic wait_idle(input int max_cycles);
        int n;
        n = 0;
        while ((exp_uops_q.size() != 0 || ret_pend != 0 || in_credits != `DC_IN_CREDITS)
               && n < max_cycles) begin
            @(posedge w_fire01);
            n++;
        end
        if (exp_uops_q.size() != 0 || ret_pend != 0 || in_credits != `DC_IN_CREDITS) begin
            $display("pipeline did not drain within %0d cycles", max_cycles);
            err_count++;
        end
    endtask

    task automatic end_test(input string name, input int e0);
        test_count++;
        if (err_count == e0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_count - e0);
        end
    endtask

    //////////////////////////////
    // output monitor and credit return
    task automatic check_window();
        win_t   eu;
        deps_t  el;
        deps_t  er;
        if (exp_uops_q.size() == 0) begin
            $display("window on o_out_valid with none expected");
            err_count++;
        end else begin
            eu = exp_uops_q.pop_front();
            el = exp_l_q.pop_front();
            er = exp_r_q.pop_front();
            for (int j = 0; j < `DC_SLOTS; j++) begin
                if (o_out_uops[j] !== eu[j]) begin
                    $display("** Error: o_out_uops[%0d] = %h, expected %h",
                             j, o_out_uops[j], eu[j]);
                    err_count++;
                end
                if (o_out_dep_l[j] !== el[j]) begin
                    $display("** Error: o_out_dep_l[%0d] = %h, expected %h",
                             j, o_out_dep_l[j], el[j]);
                    err_count++;
                end
                if (o_out_dep_r[j] !== er[j]) begin
                    $display("** Error: o_out_dep_r[%0d] = %h, expected %h",
                             j, o_out_dep_r[j], er[j]);
                    err_count++;
                end
            end
        end
    endtask

    always @(negedge w_fire01) begin
        if (rstn === 1'b1) begin
            if (o_in_credit) begin
                in_credits++;
                in_pulses++;
            end
            if (o_out_valid) begin
                rx_count++;
                if (out_credits == 0) begin
                    $display("window issued without a downstream credit");
                    err_count++;
                end
                out_credits--;
                if (auto_credit) begin
                    ret_pend++;
                end
                check_window();
            end
        end else if (o_out_valid === 1'b1 || o_in_credit === 1'b1) begin
            $display("outputs active during reset");
            err_count++;
        end
    end

    always @(posedge w_fire01) begin
        if (rstn && ret_pend > 0) begin
            i_out_credit <= 1'b1;
            ret_pend--;
            out_credits++;
        end else begin
            i_out_credit <= 1'b0;
        end
    end

    //////////////////////////////
    // directed tests
    task automatic test_reset();
        int e0;
        e0 = err_count;
        repeat (12) @(posedge w_fire01);
        if (rx_count != 0 || in_pulses != 0) begin
            $display("output activity after reset with no input sent");
            err_count++;
        end
        end_test("reset", e0);
    endtask

    task automatic test_independent();
        int     e0;
        win_t   w;
        e0 = err_count;
        for (int j = 0; j < `DC_SLOTS; j++) begin
            w[j] = mk_uop(j, 1'b1, 8 + j, 1'b1, 16 + j, 1'b1);    // no source hits a dst.
        end
        send_window(w);
        wait_idle(60);
        end_test("independent", e0);
    endtask

    task automatic test_chain();
        int     e0;
        win_t   w;
        e0 = err_count;
        w[0] = mk_uop(5, 1'b1, 0, 1'b0, 0, 1'b0);
        w[1] = mk_uop(5, 1'b1, 0, 1'b0, 0, 1'b0);
        w[2] = mk_uop(7, 1'b1, 0, 1'b0, 5, 1'b1);
        w[3] = mk_uop(5, 1'b1, 7, 1'b1, 0, 1'b0);
        w[4] = mk_uop(9, 1'b1, 5, 1'b1, 5, 1'b1);
        w[5] = mk_uop(5, 1'b1, 7, 1'b1, 9, 1'b1);
        w[6] = mk_uop(12, 1'b1, 0, 1'b0, 5, 1'b1);
        w[7] = mk_uop(3, 1'b1, 12, 1'b1, 1, 1'b1);
        send_window(w);
        // second window only crosses beats.
        w[0] = mk_uop(20, 1'b1, 0, 1'b0, 0, 1'b0);
        w[1] = mk_uop(21, 1'b1, 0, 1'b0, 0, 1'b0);
        w[2] = mk_uop(20, 1'b1, 0, 1'b0, 0, 1'b0);
        w[3] = mk_uop(22, 1'b1, 0, 1'b0, 0, 1'b0);
        for (int j = 4; j < `DC_SLOTS; j++) begin
            w[j] = mk_uop(24 + j, 1'b1, 20 + (j % 3), 1'b1, 21, 1'b1);
        end
        send_window(w);
        wait_idle(100);
        end_test("chain", e0);
    endtask

    task automatic test_flags();
        int     e0;
        win_t   w;
        e0 = err_count;
        w[0] = mk_uop(3, 1'b1, 0, 1'b0, 0, 1'b0);
        w[1] = mk_uop(10, 1'b1, 3, 1'b1, 3, 1'b0);
        w[2] = mk_uop(4, 1'b0, 0, 1'b0, 0, 1'b0);
        w[3] = mk_uop(11, 1'b1, 4, 1'b1, 4, 1'b1);
        w[4] = mk_uop(3, 1'b0, 0, 1'b0, 0, 1'b0);
        w[5] = mk_uop(12, 1'b1, 4, 1'b0, 3, 1'b1);
        w[6] = mk_uop(6, 1'b1, 0, 1'b0, 0, 1'b0);
        w[7] = mk_uop(13, 1'b1, 6, 1'b0, 3, 1'b1);
        send_window(w);
        wait_idle(60);
        end_test("valid flags", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int rx0;
        int p0;
        e0  = err_count;
        rx0 = rx_count;
        p0  = in_pulses;
        auto_credit = 1'b0;
        // two issued, one each in encoder, matrix and collector.
        for (int n = 0; n < 5; n++) begin
            send_window(rand_window());
        end
        repeat (20) @(posedge w_fire01);
        if (rx_count - rx0 != `DC_OUT_CREDITS) begin
            $display("%0d windows issued under back-pressure, expected %0d",
                     rx_count - rx0, `DC_OUT_CREDITS);
            err_count++;
        end
        if (in_pulses - p0 != 8) begin
            $display("%0d input credit pulses under back-pressure, expected 8", in_pulses - p0);
            err_count++;
        end
        @(negedge w_fire01);
        auto_credit = 1'b1;
        ret_pend    = ret_pend + `DC_OUT_CREDITS;
        @(posedge w_fire01);
        wait_idle(300);
        if (rx_count - rx0 != 5 || in_pulses - p0 != 10) begin
            $display("after release %0d windows and %0d credit pulses, expected 5 and 10",
                     rx_count - rx0, in_pulses - p0);
            err_count++;
        end
        end_test("back-pressure", e0);
    endtask

    task automatic test_random();
        int e0;
        e0 = err_count;
        for (int n = 0; n < 20; n++) begin
            send_window(rand_window());
        end
        wait_idle(800);
        end_test("random", e0);
    endtask

    initial begin
        rstn         = 1'b0;
        i_in_valid   = 1'b0;
        i_in_uops    = '0;
        i_out_credit = 1'b0;
        repeat (4) @(posedge w_fire01);
        rstn <= 1'b1;
        test_reset();
        test_independent();
        test_chain();
        test_flags();
        test_backpressure();
        test_random();
        $display("%0d tests, %0d windows checked, %0d errors",
                 test_count, rx_count, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* uop_collector.sv */
`include "dep_check_defines.svh"

module uop_collector (
    input  logic                                    w_fire01,
    input  logic                                    rstn,
    input  logic                                    i_in_valid,
    input  dep_check_pkg::uop_t [`DC_LANES-1:0]     i_in_uops,
    output logic                                    o_in_credit,
    output logic                                    o_win_valid,
    output dep_check_pkg::uop_t [`DC_SLOTS-1:0]     o_win_uops,
    input  logic                                    i_win_ready
);

    dep_check_pkg::coll_state_t                 r_state;
    dep_check_pkg::uop_t [`DC_SLOTS-1:0]        r_win;
    logic                                       r_ret_pend;
    logic                                       w_win_done;

    assign o_win_valid = (r_state == dep_check_pkg::COLL_FULL);
    assign o_win_uops  = r_win;
    assign w_win_done  = o_win_valid && i_win_ready;

    always_ff @(posedge w_fire01 or negedge rstn) begin
        if (!rstn) begin
            r_state <= dep_check_pkg::COLL_EMPTY;
        end else begin
            case (r_state)
                dep_check_pkg::COLL_EMPTY: begin
                    if (i_in_valid) r_state <= dep_check_pkg::COLL_HALF;
                end
                dep_check_pkg::COLL_HALF: begin
                    if (i_in_valid) r_state <= dep_check_pkg::COLL_FULL;
                end
                dep_check_pkg::COLL_FULL: begin
                    if (i_win_ready) r_state <= dep_check_pkg::COLL_EMPTY;
                end
                default: r_state <= dep_check_pkg::COLL_EMPTY;
            endcase
        end
    end

    // first beat is the older half.
    always_ff @(posedge w_fire01) begin
        if (i_in_valid && r_state == dep_check_pkg::COLL_EMPTY) begin
            r_win[`DC_LANES-1:0] <= i_in_uops;
        end
        if (i_in_valid && r_state == dep_check_pkg::COLL_HALF) begin
            r_win[`DC_SLOTS-1:`DC_LANES] <= i_in_uops;
        end
    end

    //////////////////////////////
    // two credit pulses per window that leaves
    always_ff @(posedge w_fire01 or negedge rstn) begin
        if (!rstn) begin
            o_in_credit <= 1'b0;
            r_ret_pend  <= 1'b0;
        end else begin
            o_in_credit <= w_win_done || r_ret_pend;
            r_ret_pend  <= w_win_done;      // second slot next cycle.
        end
    end

    //////////////////////////////
    // upstream must not overrun its credits
    assert property (@(posedge w_fire01) disable iff (!rstn)
        i_in_valid |-> r_state != dep_check_pkg::COLL_FULL);

endmodule
